/* Bender.yml */
package:
  name: uart_cmd_bridge

sources:
  - uart_cmd_pkg.sv
  - cmd_sequencer.sv
  - uart_tx_frame.sv
  - uart_rx_frame.sv
  - read_result.sv
  - uart_cmd_bridge.sv
  - target: test
    files:
      - uart_cmd_bridge_assertions.sv
      - tb_uart_cmd_bridge.sv

/* cmd_sequencer.sv */
`timescale 1ns/1ps

module cmd_sequencer #(
  parameter int gap_cycles = 100
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0]  cmd_in,
  input  logic                                cmd_vld,
  input  logic                                tx_done,
  input  logic                                read_rdy,
  output logic                                cmd_rdy,
  output logic                                tx_start,
  output logic [uart_cmd_pkg::byte_width-1:0] tx_byte,
  output logic                                rx_arm
);

  import uart_cmd_pkg::*;

  localparam int gap_w = (gap_cycles > 1) ? $clog2(gap_cycles) : 1;

  seq_state_t       state;
  cmd_t             cmd_q;
  logic [gap_w-1:0] gap_cnt;
  logic             accept;
  logic             gap_end;

  assign cmd_rdy = (state == idle);
  assign rx_arm  = (state == await_rx);
  assign accept  = cmd_vld && cmd_rdy;  // strobes outside idle are dropped here
  assign gap_end = (gap_cnt == gap_w'(gap_cycles - 1));

  // the lower byte is only ever sent from send_lo
  assign tx_byte = (state == send_lo) ? cmd_q.data : {cmd_q.is_write, cmd_q.addr};

  // ############################################################
  // command capture
  // ############################################################

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd_t'(cmd_in);
    end
  end

  // ############################################################
  // frame sequencing
  // ############################################################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;  // single cycle unless set below
      case (state)
        idle:
        begin
          if (accept)
          begin
            state    <= send_hi;
            tx_start <= 1'b1;
          end
        end
        send_hi:
        begin
          if (tx_done)
          begin
            if (cmd_q.is_write)
            begin
              state   <= gap;
              gap_cnt <= '0;
            end
            else
            begin
              state <= await_rx;
            end
          end
        end
        gap:
        begin
          if (gap_end)
          begin
            state    <= send_lo;
            tx_start <= 1'b1;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;  // tx idles high meanwhile
          end
        end
        send_lo:
        begin
          if (tx_done)
          begin
            state <= idle;
          end
        end
        await_rx:
        begin
          if (read_rdy)
          begin
            state <= idle;  // no timeout, the response is awaited forever
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* flist.f */
uart_cmd_pkg.sv
cmd_sequencer.sv
uart_tx_frame.sv
uart_rx_frame.sv
read_result.sv
uart_cmd_bridge.sv
uart_cmd_bridge_assertions.sv
tb_uart_cmd_bridge.sv

/* read_result.sv */
`timescale 1ns/1ps

module read_result (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                rx_valid,
  input  uart_cmd_pkg::rx_frame_t             rx_frame,
  output logic [uart_cmd_pkg::byte_width-1:0] read_data,
  output logic                                read_err,
  output logic                                read_rdy
);

  logic parity_ok;
  logic stop_ok;

  // odd parity means an odd number of ones over data and parity together
  assign parity_ok = ^{rx_frame.data, rx_frame.parity_bit};
  assign stop_ok   = rx_frame.stop_bit;

  always_ff @(posedge clk)
  begin
    if (rx_valid)
    begin
      read_data <= rx_frame.data;  // returned even when the checks fail
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      read_rdy <= rx_valid;
      if (rx_valid)
      begin
        read_err <= !(parity_ok && stop_ok);
      end
    end
  end

endmodule

/* tb_uart_cmd_bridge.sv */
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  import uart_cmd_pkg::*;

  localparam int clks_per_bit = 8;
  localparam int gap_cycles   = 20;
  localparam int n_cmds       = 60;
  localparam int frame_cycles = frame_bits * clks_per_bit;
  localparam int limit_cycles = 16 + n_cmds * (3 * frame_cycles + gap_cycles + 50)
                                + 4 * frame_cycles;

  logic                  clk;
  logic                  rst_n;
  logic [cmd_width-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  rx;
  logic                  tx;
  logic                  cmd_rdy;
  logic [byte_width-1:0] read_data;
  logic                  read_rdy;
  logic                  read_err;

  int                    cyc = 0;
  logic [byte_width-1:0] mon_bytes[$];  // bytes decoded from tx
  int                    mon_start[$];  // cycle of each start bit
  logic [byte_width-1:0] exp_tx[$];
  logic [byte_width-1:0] got_data[$];
  logic                  got_err[$];
  logic [byte_width-1:0] exp_data[$];
  logic                  exp_err[$];

  uart_cmd_bridge #(
    .clks_per_bit (clks_per_bit),
    .gap_cycles   (gap_cycles)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("Fail %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // ############################################################
  // serial monitor and result capture
  // ############################################################

  initial
  begin : serial_monitor
    logic [frame_bits-2:0] frame_q;  // data, parity and stop
    int                    t0;
    forever
    begin
      @(negedge clk);
      if (rst_n && !tx)
      begin
        t0 = cyc;
        repeat (clks_per_bit / 2) @(negedge clk);
        check_value(tx, 0, "tx start bit");
        for (int i = 0; i < frame_bits - 1; i++)
        begin
          repeat (clks_per_bit) @(negedge clk);
          frame_q[i] = tx;
        end
        check_value(^frame_q[byte_width:0], 1, "tx odd parity");
        check_value(frame_q[byte_width+1], 1, "tx stop bit");
        mon_bytes.push_back(frame_q[byte_width-1:0]);
        mon_start.push_back(t0);
      end
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      got_data.push_back(read_data);
      got_err.push_back(read_err);
    end
  end

  // ############################################################
  // stimulus, responder and reference model
  // ############################################################

  task automatic wait_ready();
    @(negedge clk);
    while (!cmd_rdy)
    begin
      @(negedge clk);
    end
  endtask

  task automatic send_command(input logic [cmd_width-1:0] c, input logic extra);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    check_value(cmd_rdy, 0, "cmd_rdy after accept");
    if (extra)
    begin
      @(posedge clk);
      cmd_in  <= cmd_width'($urandom);  // must be dropped while busy
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
  endtask

  // start, data lsb first, odd parity, stop
  task automatic drive_rx(input logic [byte_width-1:0] b, input logic flip);
    logic [frame_bits-1:0] f;
    f = {1'b1, (~^b) ^ flip, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < frame_bits; i++)
    begin
      rx <= f[i];
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  function automatic void model_command(input logic [cmd_width-1:0] c);
    exp_tx.push_back(c[cmd_width-1:byte_width]);
    if (c[cmd_width-1])
    begin
      exp_tx.push_back(c[byte_width-1:0]);  // a write adds the data frame
    end
  endfunction

  task automatic check_command(input logic is_write);
    int gap;
    check_value(mon_bytes.size(), exp_tx.size(), "frame count");
    if (is_write)
    begin
      gap = mon_start[1] - mon_start[0] - frame_cycles;
      check_value(gap >= gap_cycles, 1, "idle gap between write frames");
      check_value(cyc >= mon_start[1] + frame_cycles, 1, "cmd_rdy rose before the stop bit");
    end
    mon_start.delete();
    while (exp_tx.size() > 0)
    begin
      check_value(mon_bytes.pop_front(), exp_tx.pop_front(), "tx byte");
    end
    check_value(got_data.size(), exp_data.size(), "read result count");
    while (exp_data.size() > 0)
    begin
      check_value(got_data.pop_front(), exp_data.pop_front(), "read_data");
      check_value(got_err.pop_front(), exp_err.pop_front(), "read_err");
    end
  endtask

  task automatic check_reset_state(input string when);
    check_value(tx, 1, {"tx ", when});
    check_value(cmd_rdy, 1, {"cmd_rdy ", when});
    check_value(read_rdy, 0, {"read_rdy ", when});
  endtask

  initial
  begin : main_flow
    logic [cmd_width-1:0]  c;
    logic [byte_width-1:0] resp;
    logic                  flip;
    logic                  extra;
    rst_n   <= 1'b0;
    cmd_in  <= '0;
    cmd_vld <= 1'b0;
    rx      <= 1'b1;
    void'($urandom(32'h32fe7f7d));
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_reset_state("during reset");
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset_state("after reset");
    for (int n = 0; n < n_cmds; n++)
    begin
      c     = cmd_width'($urandom);
      extra = 1'($urandom % 2);
      wait_ready();
      model_command(c);
      send_command(c, extra);
      if (!c[cmd_width-1])
      begin
        while (mon_bytes.size() < 1)
        begin
          @(negedge clk);
        end
        resp = byte_width'($urandom);
        flip = (($urandom % 4) == 0);  // one response in four is corrupted
        exp_data.push_back(resp);
        exp_err.push_back(flip);
        repeat (8 + $urandom % 16) @(negedge clk);
        drive_rx(resp, flip);
      end
      wait_ready();
      check_command(c[cmd_width-1]);
    end
    repeat (4 * frame_cycles) @(negedge clk);
    check_value(mon_bytes.size(), 0, "frames after last command");
    check_value(got_data.size(), 0, "read results after last command");
    if (UUT.u_assert.fail_cnt == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
    begin
      $display("%0d assertion failures were reported", UUT.u_assert.fail_cnt);
      $display("CHECKS FAILED");
      $fatal(1, "assertion failures");
    end
  end

  initial
  begin : watchdog
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the test did not finish within %0d clock cycles", limit_cycles);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* uart_cmd_bridge.sv */
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int clks_per_bit = 434,
  parameter int gap_cycles   = 100
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0]  cmd_in,
  input  logic                                cmd_vld,
  input  logic                                rx,
  output logic                                tx,
  output logic                                cmd_rdy,
  output logic [uart_cmd_pkg::byte_width-1:0] read_data,
  output logic                                read_rdy,
  output logic                                read_err
);

  import uart_cmd_pkg::*;

  logic                  tx_start;
  logic [byte_width-1:0] tx_byte;
  logic                  tx_done;
  logic                  rx_arm;
  logic                  rx_valid;
  rx_frame_t             rx_frame;

  cmd_sequencer #(
    .gap_cycles (gap_cycles)
  ) u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .tx_done  (tx_done),
    .read_rdy (read_rdy),  // result pulse closes a read
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .rx_arm   (rx_arm)
  );

  uart_tx_frame #(
    .clks_per_bit (clks_per_bit)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame #(
    .clks_per_bit (clks_per_bit)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_arm   (rx_arm),
    .rx_valid (rx_valid),
    .rx_frame (rx_frame)
  );

  read_result u_res (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame),
    .read_data (read_data),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

endmodule

/* uart_cmd_bridge_assertions.sv */
`timescale 1ns/1ps

module uart_cmd_bridge_assertions (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     cmd_vld,
  input logic                     cmd_rdy,
  input logic                     tx,
  input logic                     read_rdy,
  input uart_cmd_pkg::seq_state_t seq_state
);

  import uart_cmd_pkg::*;

  int fail_cnt = 0;  // read by the testbench at the end of the run

  property p_idle_tx_high;
    @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx;
  endproperty

  property p_read_rdy_pulse;
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy;
  endproperty

  // an accepted command always starts with the upper byte
  property p_busy_after_accept;
    @(posedge clk) disable iff (!rst_n)
      (cmd_vld && cmd_rdy) |=> (!cmd_rdy && seq_state == send_hi);
  endproperty

  a_idle_tx_high: assert property (p_idle_tx_high)
  else
  begin
    fail_cnt++;
    $error("tx is low while cmd_rdy is high");
  end

  a_read_rdy_pulse: assert property (p_read_rdy_pulse)
  else
  begin
    fail_cnt++;
    $error("read_rdy stayed high for two cycles");
  end

  a_busy_after_accept: assert property (p_busy_after_accept)
  else
  begin
    fail_cnt++;
    $error("cmd_rdy did not fall after an accepted command");
  end

endmodule

bind uart_cmd_bridge uart_cmd_bridge_assertions u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .cmd_vld   (cmd_vld),
  .cmd_rdy   (cmd_rdy),
  .tx        (tx),
  .read_rdy  (read_rdy),
  .seq_state (u_seq.state)
);

/* uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // ############################################################
  // widths
  // ############################################################

  localparam int cmd_width  = 16;
  localparam int byte_width = 8;
  localparam int addr_width = cmd_width - byte_width - 1;  // upper byte minus the write flag

  // start, data, odd parity and stop
  localparam int frame_bits = byte_width + 3;

  // ############################################################
  // shared types
  // ############################################################

  // same bit layout as the raw host command, bit 15 first
  typedef struct packed {
    logic                  is_write;
    logic [addr_width-1:0] addr;
    logic [byte_width-1:0] data;
  } cmd_t;

  // one received frame without its start bit
  typedef struct packed {
    logic [byte_width-1:0] data;
    logic                  parity_bit;
    logic                  stop_bit;
  } rx_frame_t;

  typedef enum logic [2:0] {
    idle,
    send_hi,
    gap,
    send_lo,
    await_rx
  } seq_state_t;

endpackage

/* uart_rx_frame.sv */
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  input  logic                    rx_arm,
  output logic                    rx_valid,
  output uart_cmd_pkg::rx_frame_t rx_frame
);

  import uart_cmd_pkg::*;

  localparam int bits_in = $bits(rx_frame_t);
  localparam int baud_w  = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int bit_w   = $clog2(bits_in + 1);

  typedef enum logic [1:0] {
    rx_hunt,
    rx_start,
    rx_shift
  } rx_state_t;

  rx_state_t          state;
  logic               rx_meta;
  logic               rx_sync;
  logic               rx_prev;
  logic [baud_w-1:0]  baud_cnt;
  logic [bit_w-1:0]   bit_cnt;
  logic [bits_in-1:0] shift_q;
  logic               fall;
  logic               half_end;
  logic               full_end;

  assign fall     = rx_arm && rx_prev && !rx_sync;
  assign half_end = (baud_cnt == baud_w'(clks_per_bit / 2 - 1));
  assign full_end = (baud_cnt == baud_w'(clks_per_bit - 1));

  // first bit in ends up lowest, so data sits in the bottom byte
  assign rx_frame.data       = shift_q[byte_width-1:0];
  assign rx_frame.parity_bit = shift_q[byte_width];
  assign rx_frame.stop_bit   = shift_q[byte_width+1];

  always_ff @(posedge clk)
  begin
    if (state == rx_shift && full_end)
    begin
      shift_q <= {rx_sync, shift_q[bits_in-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      state    <= rx_hunt;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      rx_prev  <= rx_sync;
      rx_valid <= 1'b0;
      case (state)
        rx_hunt:
        begin
          if (fall)
          begin
            state    <= rx_start;
            baud_cnt <= '0;
          end
        end
        rx_start:
        begin
          if (half_end)
          begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? rx_hunt : rx_shift;  // a glitch goes back to hunting
          end
          else
          begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_shift:
        begin
          if (full_end)
          begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == bit_w'(bits_in - 1))
            begin
              rx_valid <= 1'b1;  // stop bit sampled
              state    <= rx_hunt;
            end
          end
          else
          begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= rx_hunt;
        end
      endcase
    end
  end

endmodule

/* uart_tx_frame.sv */
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                tx_start,
  input  logic [uart_cmd_pkg::byte_width-1:0] tx_byte,
  output logic                                tx,
  output logic                                tx_done
);

  import uart_cmd_pkg::*;

  localparam int baud_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int bit_w  = $clog2(frame_bits);

  logic                  busy;
  logic [baud_w-1:0]     baud_cnt;
  logic [bit_w-1:0]      bit_cnt;
  logic [frame_bits-2:0] shift_q;  // everything after the start bit
  logic                  baud_end;
  logic                  last_bit;

  assign baud_end = (baud_cnt == baud_w'(clks_per_bit - 1));
  assign last_bit = (bit_cnt == bit_w'(frame_bits - 1));
  assign tx_done  = busy && baud_end && last_bit;  // last cycle of the stop bit

  // stop, parity, data with bit 0 leaving first
  always_ff @(posedge clk)
  begin
    if (tx_start && !busy)
    begin
      shift_q <= {1'b1, ~^tx_byte, tx_byte};
    end
    else if (busy && baud_end)
    begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else if (!busy)
    begin
      if (tx_start)
      begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
        tx       <= 1'b0;  // start bit
      end
    end
    else if (baud_end)
    begin
      baud_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;  // tx already sits at the stop level
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= shift_q[0];
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule
